/* opDecodePkg.sv */
// ####################################################################
// Shared types for the decoder. Register codes above R15 are pseudo
// registers; ucmdE values are the codes seen on idUCmd.
// ####################################################################
package opDecodePkg;

	typedef logic [6:0] regIdxT;	// register number
	typedef logic [31:0] immT;
	typedef logic [3:0] stepT;	// instruction length in bytes

	localparam regIdxT R0 = 7'h00;
	localparam regIdxT R15 = 7'h0F;
	localparam regIdxT MR_IMM = 7'h50;	// operand comes from idImm
	localparam regIdxT MR_MEMINC = 7'h51;	// post-increment
	localparam regIdxT MR_MEMDEC = 7'h52;	// pre-decrement
	localparam regIdxT PCW = 7'h53;	// PC base, word scaled
	localparam regIdxT PCL = 7'h54;	// PC base, long scaled
	localparam regIdxT ZZR = 7'h5F;	// no register

	localparam logic [7:0] OP_PFX8A = 8'h8A;
	localparam logic [7:0] OP_PFX8E = 8'h8E;

	typedef enum logic [7:0] {
		UCMD_NONE = 8'h00, UCMD_MOV_RR = 8'h01, UCMD_MOV_RI = 8'h02,
		UCMD_MOVB_RM = 8'h03, UCMD_MOVW_RM = 8'h04, UCMD_MOVL_RM = 8'h05,
		UCMD_MOVB_MR = 8'h06, UCMD_MOVW_MR = 8'h07, UCMD_MOVL_MR = 8'h08,
		UCMD_LEAB_MR = 8'h09, UCMD_LEAW_MR = 8'h0A, UCMD_LEAL_MR = 8'h0B,
		UCMD_LEAQ_MR = 8'h0C,
		UCMD_ALU_ADD = 8'h10, UCMD_ALU_SUB = 8'h11, UCMD_ALU_MUL = 8'h12,
		UCMD_ALU_AND = 8'h13, UCMD_ALU_OR = 8'h14, UCMD_ALU_XOR = 8'h15,
		UCMD_ALU_SHLD = 8'h16, UCMD_ALU_SHLDR = 8'h17, UCMD_ALU_SHAD = 8'h18,
		UCMD_ALU_SHADR = 8'h19, UCMD_ALU_ADDC = 8'h1A, UCMD_ALU_ADDV = 8'h1B,
		UCMD_ALU_SUBC = 8'h1C, UCMD_ALU_SUBV = 8'h1D, UCMD_ALU_NOT = 8'h1E,
		UCMD_ALU_EXTUB = 8'h20, UCMD_ALU_EXTUW = 8'h21, UCMD_ALU_EXTSB = 8'h22,
		UCMD_ALU_EXTSW = 8'h23,
		UCMD_CMP_EQ = 8'h30, UCMD_CMP_HS = 8'h31, UCMD_CMP_GE = 8'h32,
		UCMD_CMP_HI = 8'h33, UCMD_CMP_GT = 8'h34, UCMD_CMP_TST = 8'h35,
		UCMD_BRA = 8'h40, UCMD_BSR = 8'h41, UCMD_BT = 8'h42, UCMD_BF = 8'h43,
		UCMD_BTS = 8'h44, UCMD_BFS = 8'h45, UCMD_RTS = 8'h46,
		UCMD_UDBRK = 8'hFF
	} ucmdE;

	typedef enum logic [3:0] {
		XF_CST, XF_N, XF_MOV_NS, XF_MOV_NSO, XF_MOV_NSJ, XF_MOV_NSDEC,
		XF_ARI_NS, XF_ARI_NST, XF_ARI_ST, XF_CMP_ST, XF_ARI_NNI,
		XF_BR_D8, XF_BR_D12, XF_NST_8E, XF_N_C
	} xformE;

	typedef enum logic [1:0] {
		XZ_SX, XZ_ZX, XZ_PINC, XZ_PDEC
	} xformZxE;

	typedef struct packed {
		logic [3:0] op;
		logic [3:0] n;
		logic [3:0] m;
		logic [3:0] d;
	} cmdNibT;

	typedef struct packed {
		logic [3:0] op;
		logic [3:0] n;
		logic [7:0] imm8;
	} cmdByteT;

	// one 16-bit command word, seen as nibbles or as op/n/imm8
	typedef union packed {
		cmdNibT nib;
		cmdByteT byt;
	} cmdWordU;

endpackage

/* decodeIfs.sv */
// ####################################################################
// Stage links of the decoder. valid qualifies all other fields and
// there is no ready; every valid word is taken.
// ####################################################################
`timescale 1ns/1ns

interface splitIf;
	logic valid;
	opDecodePkg::cmdWordU cmdWord;
	logic [7:0] pfxImm;	// prefix byte of 8A/8E forms
	logic isOp8E;
	logic isOp8A;
	opDecodePkg::stepT stepPc;
	opDecodePkg::stepT stepPc2;

	modport producer(output valid, cmdWord, pfxImm, isOp8E, isOp8A, stepPc, stepPc2);
	modport consumer(input valid, cmdWord, pfxImm, isOp8E, isOp8A, stepPc, stepPc2);
endinterface

interface classIf;
	opDecodePkg::ucmdE uCmd;
	opDecodePkg::xformE xform;
	opDecodePkg::xformZxE xformZx;
	opDecodePkg::immT constImm;	// shift amounts, PC-relative disp
	opDecodePkg::regIdxT constRegN;	// fixed destination

	modport producer(output uCmd, xform, xformZx, constImm, constRegN);
	modport consumer(input uCmd, xform, xformZx, constImm, constRegN);
endinterface

/* prefixSplit.sv */
// ####################################################################
// Stage 1. Only the 8A and 8E 32-bit forms are recognized, and only
// when enableBjx1 is set. For 8A the command word is the low halfword
// of the 24-bit immediate; the 8A flag carries the meaning.
// ####################################################################
`timescale 1ns/1ns

module prefixSplit #(
	parameter bit enableBjx1 = 1
) (
	input logic clk,
	input logic rstN,
	input logic istrValid,
	input logic [47:0] istrWord,
	splitIf.producer split
);

	logic is8A, is8E;
	logic [7:0] nextByte;	// first byte of the following instruction

	always_comb begin
		is8A = enableBjx1 && (istrWord[15:8] == opDecodePkg::OP_PFX8A);
		is8E = enableBjx1 && (istrWord[15:8] == opDecodePkg::OP_PFX8E);
		nextByte = (is8A || is8E) ? istrWord[47:40] : istrWord[31:24];
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			split.valid <= 1'b0;
		end else begin
			split.valid <= istrValid;
		end
	end

	// decoded fields of the word
	always_ff @(posedge clk) begin
		split.isOp8A <= is8A;
		split.isOp8E <= is8E;
		split.pfxImm <= istrWord[7:0];
		split.cmdWord <= (is8A || is8E) ? istrWord[31:16] : istrWord[15:0];
		split.stepPc <= (is8A || is8E) ? 4'd4 : 4'd2;
		if (enableBjx1 && (nextByte == 8'h8A || nextByte == 8'h8C || nextByte == 8'h8E))
			split.stepPc2 <= 4'd4;
		else
			split.stepPc2 <= 4'd2;
	end

	// a valid word needs a known first byte to set its length
	assert property (@(posedge clk) disable iff (!rstN)
		istrValid |-> !$isunknown(istrWord[15:8]));

endmodule

/* opClassify.sv */
// ####################################################################
// Combinational opcode classifier. Anything outside the kept groups
// decodes as UDBRK with form CST.
// ####################################################################
`timescale 1ns/1ns

module opClassify (
	splitIf.consumer split,
	classIf.producer cls
);

	logic [3:0] op, n, m, d;

	always_comb begin
		op = split.cmdWord.nib.op;
		n = split.cmdWord.nib.n;
		m = split.cmdWord.nib.m;
		d = split.cmdWord.nib.d;

		cls.uCmd = opDecodePkg::UCMD_UDBRK;
		cls.xform = opDecodePkg::XF_CST;
		cls.xformZx = opDecodePkg::XZ_SX;
		cls.constImm = '0;
		cls.constRegN = opDecodePkg::ZZR;

		if (split.isOp8A) begin
			cls.uCmd = opDecodePkg::UCMD_MOV_RI;	// imm24 to R0
			cls.constRegN = opDecodePkg::R0;
		end else begin
			casez ({op, n, m, d})
				16'h0z09: cls.uCmd = opDecodePkg::UCMD_NONE;
				16'h0z0B: cls.uCmd = opDecodePkg::UCMD_RTS;
				16'h1zzz: begin	// MOV.L Rm, @(Rn, disp)
					cls.uCmd = opDecodePkg::UCMD_MOVL_RM;
					cls.xform = opDecodePkg::XF_MOV_NSJ;
				end
				16'h5zzz: begin
					cls.uCmd = opDecodePkg::UCMD_MOVL_MR;
					cls.xform = opDecodePkg::XF_MOV_NSJ;
				end
				16'h2zz0, 16'h2zz1, 16'h2zz2: begin	// stores @Rn
					cls.uCmd = (d[1:0] == 2'd0) ? opDecodePkg::UCMD_MOVB_RM :
						(d[1:0] == 2'd1) ? opDecodePkg::UCMD_MOVW_RM : opDecodePkg::UCMD_MOVL_RM;
					cls.xform = opDecodePkg::XF_MOV_NS;
				end
				16'h2zz4, 16'h2zz5, 16'h2zz6: begin	// stores @-Rn
					cls.uCmd = (d[1:0] == 2'd0) ? opDecodePkg::UCMD_MOVB_RM :
						(d[1:0] == 2'd1) ? opDecodePkg::UCMD_MOVW_RM : opDecodePkg::UCMD_MOVL_RM;
					cls.xform = opDecodePkg::XF_MOV_NSDEC;
					cls.xformZx = opDecodePkg::XZ_PDEC;
				end
				16'h2zz8: begin
					cls.uCmd = opDecodePkg::UCMD_CMP_TST;
					cls.xform = opDecodePkg::XF_CMP_ST;
				end
				16'h2zz9, 16'h2zzA, 16'h2zzB: begin	// AND, XOR, OR
					cls.uCmd = (d == 4'h9) ? opDecodePkg::UCMD_ALU_AND :
						(d == 4'hA) ? opDecodePkg::UCMD_ALU_XOR : opDecodePkg::UCMD_ALU_OR;
					cls.xform = opDecodePkg::XF_ARI_NST;
					cls.xformZx = opDecodePkg::XZ_ZX;
				end
				16'h3zz0, 16'h3zz2, 16'h3zz3, 16'h3zz6, 16'h3zz7: begin
					cls.xform = opDecodePkg::XF_CMP_ST;
					case (d)
						4'h0: cls.uCmd = opDecodePkg::UCMD_CMP_EQ;
						4'h2: cls.uCmd = opDecodePkg::UCMD_CMP_HS;
						4'h3: cls.uCmd = opDecodePkg::UCMD_CMP_GE;
						4'h6: cls.uCmd = opDecodePkg::UCMD_CMP_HI;
						default: cls.uCmd = opDecodePkg::UCMD_CMP_GT;
					endcase
				end
				16'h3zz8, 16'h3zzA, 16'h3zzB, 16'h3zzC, 16'h3zzE, 16'h3zzF: begin
					cls.xform = opDecodePkg::XF_ARI_NST;
					cls.xformZx = opDecodePkg::XZ_ZX;
					case (d)
						4'h8: cls.uCmd = opDecodePkg::UCMD_ALU_SUB;
						4'hA: cls.uCmd = opDecodePkg::UCMD_ALU_SUBC;
						4'hB: cls.uCmd = opDecodePkg::UCMD_ALU_SUBV;
						4'hC: cls.uCmd = opDecodePkg::UCMD_ALU_ADD;
						4'hE: cls.uCmd = opDecodePkg::UCMD_ALU_ADDC;
						default: cls.uCmd = opDecodePkg::UCMD_ALU_ADDV;
					endcase
				end
				16'h4zz3: begin	// three-operand ALU under 8E
					if (split.isOp8E && m <= 4'h9) begin
						cls.xform = opDecodePkg::XF_NST_8E;
						case (m)
							4'h0: cls.uCmd = opDecodePkg::UCMD_ALU_ADD;
							4'h1: cls.uCmd = opDecodePkg::UCMD_ALU_SUB;
							4'h2: cls.uCmd = opDecodePkg::UCMD_ALU_MUL;
							4'h3: cls.uCmd = opDecodePkg::UCMD_ALU_AND;
							4'h4: cls.uCmd = opDecodePkg::UCMD_ALU_OR;
							4'h5: cls.uCmd = opDecodePkg::UCMD_ALU_XOR;
							4'h6: cls.uCmd = opDecodePkg::UCMD_ALU_SHLD;
							4'h7: cls.uCmd = opDecodePkg::UCMD_ALU_SHLDR;
							4'h8: cls.uCmd = opDecodePkg::UCMD_ALU_SHAD;
							default: cls.uCmd = opDecodePkg::UCMD_ALU_SHADR;
						endcase
					end
				end
				16'h4z08, 16'h4z18, 16'h4z28, 16'h4z09, 16'h4z19, 16'h4z29: begin
					cls.uCmd = opDecodePkg::UCMD_ALU_SHLD;
					cls.xform = opDecodePkg::XF_N_C;
					case (m)
						4'h0: cls.constImm = 32'd2;
						4'h1: cls.constImm = 32'd8;
						default: cls.constImm = 32'd16;
					endcase
					if (d[0])	// 4xx9 shifts right
						cls.constImm = -cls.constImm;
				end
				16'h6zz0, 16'h6zz1, 16'h6zz2: begin
					cls.uCmd = (d[1:0] == 2'd0) ? opDecodePkg::UCMD_MOVB_MR :
						(d[1:0] == 2'd1) ? opDecodePkg::UCMD_MOVW_MR : opDecodePkg::UCMD_MOVL_MR;
					cls.xform = opDecodePkg::XF_MOV_NS;
				end
				16'h6zz3: begin
					cls.uCmd = opDecodePkg::UCMD_MOV_RR;
					cls.xform = opDecodePkg::XF_ARI_NS;
				end
				16'h6zz4, 16'h6zz5, 16'h6zz6, 16'h6zz7: begin
					if (split.isOp8E) begin	// LEA replaces the load
						cls.xform = opDecodePkg::XF_MOV_NSO;
						case (d[1:0])
							2'd0: cls.uCmd = opDecodePkg::UCMD_LEAB_MR;
							2'd1: cls.uCmd = opDecodePkg::UCMD_LEAW_MR;
							2'd2: cls.uCmd = opDecodePkg::UCMD_LEAL_MR;
							default: cls.uCmd = opDecodePkg::UCMD_LEAQ_MR;
						endcase
					end else if (d == 4'h7) begin
						cls.uCmd = opDecodePkg::UCMD_ALU_NOT;
						cls.xform = opDecodePkg::XF_ARI_NS;
					end else begin
						cls.uCmd = (d[1:0] == 2'd0) ? opDecodePkg::UCMD_MOVB_MR :
							(d[1:0] == 2'd1) ? opDecodePkg::UCMD_MOVW_MR :
							opDecodePkg::UCMD_MOVL_MR;
						cls.xform = opDecodePkg::XF_MOV_NSDEC;
						cls.xformZx = opDecodePkg::XZ_PINC;
					end
				end
				16'h6zzC, 16'h6zzD, 16'h6zzE, 16'h6zzF: begin
					cls.xform = opDecodePkg::XF_ARI_NS;
					case (d[1:0])
						2'd0: cls.uCmd = opDecodePkg::UCMD_ALU_EXTUB;
						2'd1: cls.uCmd = opDecodePkg::UCMD_ALU_EXTUW;
						2'd2: cls.uCmd = opDecodePkg::UCMD_ALU_EXTSB;
						default: cls.uCmd = opDecodePkg::UCMD_ALU_EXTSW;
					endcase
				end
				16'h7zzz: begin
					cls.uCmd = opDecodePkg::UCMD_ALU_ADD;
					cls.xform = opDecodePkg::XF_ARI_NNI;
				end
				16'h89zz, 16'h8Bzz, 16'h8Dzz, 16'h8Fzz: begin
					cls.xform = opDecodePkg::XF_BR_D8;
					case (n)
						4'h9: cls.uCmd = opDecodePkg::UCMD_BT;
						4'hB: cls.uCmd = opDecodePkg::UCMD_BF;
						4'hD: cls.uCmd = opDecodePkg::UCMD_BTS;
						default: cls.uCmd = opDecodePkg::UCMD_BFS;
					endcase
				end
				16'h9zzz, 16'hDzzz: begin	// PC-relative loads
					cls.uCmd = (op == 4'h9) ? opDecodePkg::UCMD_MOVW_MR : opDecodePkg::UCMD_MOVL_MR;
					cls.constRegN = {3'b000, n};
					cls.constImm = {24'h0, split.cmdWord.byt.imm8};
				end
				16'hAzzz, 16'hBzzz: begin
					cls.uCmd = (op == 4'hA) ? opDecodePkg::UCMD_BRA : opDecodePkg::UCMD_BSR;
					cls.xform = opDecodePkg::XF_BR_D12;
				end
				16'hEzzz: begin
					cls.uCmd = opDecodePkg::UCMD_MOV_RI;
					cls.xform = opDecodePkg::XF_ARI_NNI;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

/* operandForm.sv */
// ####################################################################
// Stage 2. Builds register numbers and the immediate from the operand
// form and registers them. Unassigned registers are ZZR, imm is 0.
// ####################################################################
`timescale 1ns/1ns

module operandForm (
	input logic clk,
	input logic rstN,
	splitIf.consumer split,
	classIf.consumer cls,
	output logic idValid,
	output opDecodePkg::regIdxT idRegN,
	output opDecodePkg::regIdxT idRegS,
	output opDecodePkg::regIdxT idRegT,
	output opDecodePkg::immT idImm,
	output opDecodePkg::ucmdE idUCmd,
	output opDecodePkg::stepT idStepPc,
	output opDecodePkg::stepT idStepPc2
);

	opDecodePkg::regIdxT regN, regM, regO, regS8E, regT8E;
	opDecodePkg::regIdxT nxtN, nxtS, nxtT;
	opDecodePkg::immT immZx4, immSx8, immSx12, immZx4p, immZx8p, immSx8p;
	opDecodePkg::immT immSx12p, immSx16p, immSx20p, immSx24;
	opDecodePkg::immT nxtImm;
	logic [7:0] pfx;
	logic [11:0] tail;
	logic [7:0] imm8;
	logic pf8E;

	always_comb begin
		pfx = split.pfxImm;
		pf8E = split.isOp8E;
		tail = {split.cmdWord.nib.n, split.cmdWord.nib.m, split.cmdWord.nib.d};
		imm8 = split.cmdWord.byt.imm8;

		regN = {3'b000, split.cmdWord.nib.n};
		regM = {3'b000, split.cmdWord.nib.m};
		regO = {3'b000, split.cmdWord.nib.d};
		regS8E = {3'b000, pfx[7:4]};
		regT8E = {3'b000, pfx[3:0]};

		immZx4 = {28'h0, split.cmdWord.nib.d};
		immSx8 = {{24{imm8[7]}}, imm8};
		immSx12 = {{20{tail[11]}}, tail};
		immZx4p = {28'h0, pfx[3:0]};
		immZx8p = {24'h0, pfx};
		immSx8p = {{24{pfx[7]}}, pfx};
		immSx12p = {{20{pfx[7]}}, pfx, split.cmdWord.nib.m};	// prefix above m
		immSx16p = {{16{pfx[7]}}, pfx, imm8};
		immSx20p = {{12{pfx[7]}}, pfx, tail};
		immSx24 = {{8{pfx[7]}}, pfx, split.cmdWord};	// prefix then 2nd halfword of 8A

		nxtN = opDecodePkg::ZZR;
		nxtS = opDecodePkg::ZZR;
		nxtT = opDecodePkg::ZZR;
		nxtImm = '0;

		case (cls.xform)
			opDecodePkg::XF_CST: begin
				nxtN = cls.constRegN;
				if (cls.constRegN != opDecodePkg::ZZR && !split.isOp8A)	// PC-relative
					nxtS = (cls.uCmd == opDecodePkg::UCMD_MOVW_MR) ? opDecodePkg::PCW :
						opDecodePkg::PCL;
				nxtImm = split.isOp8A ? immSx24 : cls.constImm;
			end
			opDecodePkg::XF_N: begin
				nxtN = regN;
				nxtS = regN;
			end
			opDecodePkg::XF_MOV_NS: begin
				nxtN = regN;
				nxtS = regM;
				if (pf8E)
					nxtImm = immSx8p;
			end
			opDecodePkg::XF_MOV_NSO: begin
				nxtN = regN;
				nxtS = regM;
				nxtT = pf8E ? regS8E : opDecodePkg::R0;
				nxtImm = pf8E ? immZx4p : '0;
			end
			opDecodePkg::XF_MOV_NSJ: begin
				nxtN = regN;
				nxtS = regM;
				if (pf8E) begin
					nxtT = regO;
					nxtImm = immSx8p;
				end else begin
					nxtImm = immZx4;
				end
			end
			opDecodePkg::XF_MOV_NSDEC: begin
				nxtN = regN;
				nxtS = regM;
				nxtT = (cls.xformZx == opDecodePkg::XZ_PINC) ? opDecodePkg::MR_MEMINC :
					opDecodePkg::MR_MEMDEC;
			end
			opDecodePkg::XF_ARI_NS, opDecodePkg::XF_ARI_ST: begin
				nxtN = regN;
				nxtS = regM;
			end
			opDecodePkg::XF_ARI_NST: begin
				if (pf8E) begin	// Rm op imm8 into Rn
					nxtN = regN;
					nxtS = regM;
					nxtT = opDecodePkg::MR_IMM;
					nxtImm = (cls.xformZx == opDecodePkg::XZ_ZX) ? immZx8p : immSx8p;
				end else begin
					nxtN = regN;
					nxtS = regN;
					nxtT = regM;
				end
			end
			opDecodePkg::XF_CMP_ST: begin
				nxtS = regN;
				nxtT = pf8E ? opDecodePkg::MR_IMM : regM;
				if (pf8E)
					nxtImm = immSx12p;
			end
			opDecodePkg::XF_ARI_NNI: begin
				nxtN = regN;
				nxtS = regN;
				nxtT = opDecodePkg::MR_IMM;
				nxtImm = pf8E ? immSx16p : immSx8;
			end
			opDecodePkg::XF_BR_D8: nxtImm = pf8E ? immSx16p : immSx8;
			opDecodePkg::XF_BR_D12: nxtImm = pf8E ? immSx20p : immSx12;
			opDecodePkg::XF_NST_8E: begin
				nxtN = regN;
				nxtS = regS8E;
				nxtT = regT8E;
			end
			opDecodePkg::XF_N_C: begin
				nxtN = regN;
				nxtS = regN;
				nxtT = opDecodePkg::MR_IMM;
				nxtImm = cls.constImm;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			idValid <= 1'b0;
		end else begin
			idValid <= split.valid;
		end
	end

	always_ff @(posedge clk) begin
		idRegN <= nxtN;
		idRegS <= nxtS;
		idRegT <= nxtT;
		idImm <= nxtImm;
		idUCmd <= cls.uCmd;
		idStepPc <= split.stepPc;
		idStepPc2 <= split.stepPc2;
	end

	assert property (@(posedge clk) disable iff (!rstN) !$isunknown(idValid));

endmodule

/* opDecodeTop.sv */
// ####################################################################
// Two-stage decoder, fixed latency of 2 cycles, one word per cycle.
// No back-pressure; the consumer takes every idValid word.
// ####################################################################
`timescale 1ns/1ns

module opDecodeTop #(
	parameter bit enableBjx1 = 1
) (
	input logic clk,
	input logic rstN,
	input logic istrValid,
	input logic [47:0] istrWord,
	output logic idValid,
	output opDecodePkg::regIdxT idRegN,
	output opDecodePkg::regIdxT idRegS,
	output opDecodePkg::regIdxT idRegT,
	output opDecodePkg::immT idImm,
	output opDecodePkg::ucmdE idUCmd,
	output opDecodePkg::stepT idStepPc,
	output opDecodePkg::stepT idStepPc2
);

	splitIf split();
	classIf cls();

	prefixSplit #(.enableBjx1(enableBjx1)) uSplit (
		.clk(clk), .rstN(rstN), .istrValid(istrValid), .istrWord(istrWord), .split(split)
	);

	opClassify uClassify (.split(split), .cls(cls));

	operandForm uForm (
		.clk(clk), .rstN(rstN), .split(split), .cls(cls),
		.idValid(idValid), .idRegN(idRegN), .idRegS(idRegS), .idRegT(idRegT),
		.idImm(idImm), .idUCmd(idUCmd), .idStepPc(idStepPc), .idStepPc2(idStepPc2)
	);

endmodule

/* tbOpDecode.sv */
// ####################################################################
// Decoder testbench. Words and expected results come from
// opDecode_stimulus.txt; outputs are due 2 cycles after the drive edge.
// ####################################################################
`timescale 1ns/1ns

module tbOpDecode;

	localparam int stimCount = 26;
	localparam int fieldCount = 8;	// values per stimulus line
	localparam int waitLimit = 10;

	typedef struct packed {
		logic [6:0] regN;
		logic [6:0] regS;
		logic [6:0] regT;
		logic [31:0] imm;
		logic [7:0] uCmd;
		logic [3:0] stepPc;
		logic [3:0] stepPc2;
		logic [31:0] cycle;	// cycle count when idValid is due
	} expRecT;

	logic clk, rstN, istrValid;
	logic [47:0] istrWord;
	logic idValid;
	opDecodePkg::regIdxT idRegN, idRegS, idRegT;
	opDecodePkg::immT idImm;
	opDecodePkg::ucmdE idUCmd;
	opDecodePkg::stepT idStepPc, idStepPc2;

	logic [47:0] stimMem [0:stimCount*fieldCount-1];
	expRecT expQ[$];
	int cycleCount = 0;
	integer seed;

	opDecodeTop #(.enableBjx1(1)) opDecodeTop_inst (
		.clk(clk), .rstN(rstN), .istrValid(istrValid), .istrWord(istrWord),
		.idValid(idValid), .idRegN(idRegN), .idRegS(idRegS), .idRegT(idRegT),
		.idImm(idImm), .idUCmd(idUCmd), .idStepPc(idStepPc), .idStepPc2(idStepPc2)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cycleCount <= cycleCount + 1;

	task automatic stopRun();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [47:0] expected,
			input logic [47:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
			stopRun();
		end
	endtask

	task automatic idleCycle();
		@(posedge clk);
		#1;
		istrValid = 1'b0;
		istrWord = '0;
	endtask

	task automatic driveRecord(input int idx);
		int base;
		expRecT rec;
		base = idx * fieldCount;
		istrValid = 1'b1;
		istrWord = stimMem[base];
		rec.regN = stimMem[base+1][6:0];
		rec.regS = stimMem[base+2][6:0];
		rec.regT = stimMem[base+3][6:0];
		rec.imm = stimMem[base+4][31:0];
		rec.uCmd = stimMem[base+5][7:0];
		rec.stepPc = stimMem[base+6][3:0];
		rec.stepPc2 = stimMem[base+7][3:0];
		rec.cycle = 32'(cycleCount + 2);	// two register stages
		expQ.push_back(rec);
	endtask

	task automatic runDriver();
		int gapLen;
		repeat (3) idleCycle();	// idValid must stay low here
		for (int i = 0; i < stimCount; i++) begin
			@(posedge clk);
			#1;
			driveRecord(i);
			if ((i / 8) % 2 == 1) begin	// gap phase
				gapLen = ($random(seed) & 32'h3) + 1;
				repeat (gapLen) idleCycle();
			end
		end
		idleCycle();
	endtask

	task automatic runChecker();
		int waited;
		expRecT rec;
		for (int j = 0; j < stimCount; j++) begin
			waited = 0;
			@(posedge clk);
			#1;
			while (!idValid) begin
				waited++;
				if (waited >= waitLimit) begin
					$display("timeout waiting for idValid of record %0d", j);
					stopRun();
				end
				@(posedge clk);
				#1;
			end
			if (expQ.size() == 0) begin
				$display("idValid went high with no word in flight");
				stopRun();
			end
			rec = expQ.pop_front();
			checkValue("idValid cycle", 48'(rec.cycle), 48'(cycleCount));
			checkValue("idRegN", 48'(rec.regN), 48'(idRegN));
			checkValue("idRegS", 48'(rec.regS), 48'(idRegS));
			checkValue("idRegT", 48'(rec.regT), 48'(idRegT));
			checkValue("idImm", 48'(rec.imm), 48'(idImm));
			checkValue("idUCmd", 48'(rec.uCmd), 48'(idUCmd));
			checkValue("idStepPc", 48'(rec.stepPc), 48'(idStepPc));
			checkValue("idStepPc2", 48'(rec.stepPc2), 48'(idStepPc2));
		end
	endtask

	initial begin
		seed = 32'hbd2b;
		rstN = 1'b0;
		istrValid = 1'b0;
		istrWord = '0;
		$readmemh("opDecode_stimulus.txt", stimMem);

		repeat (3) begin
			@(posedge clk);
			#1;
			checkValue("idValid in reset", 48'h0, 48'(idValid));
		end
		rstN = 1'b1;

		fork
			runDriver();
			runChecker();
		join

		repeat (4) begin	// nothing extra may come out
			@(posedge clk);
			#1;
			checkValue("idValid after last word", 48'h0, 48'(idValid));
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* opDecode.f */
opDecodePkg.sv
decodeIfs.sv
prefixSplit.sv
opClassify.sv
operandForm.sv
opDecodeTop.sv
tbOpDecode.sv

/* run.sh */
#!/bin/sh
# builds and runs the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f opDecode.f --top-module tbOpDecode -o simOpDecode

./obj_dir/simOpDecode > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
else
	exit 1
fi

/* opDecode_stimulus.txt */
// columns: istrWord regN regS regT imm uCmd stepPc stepPc2 (all hex)
// one instruction per line, expected decode after the word
000000002539 05 05 03 00000000 13 2 2
0000000071F0 01 01 50 FFFFFFF0 10 2 2
000000007305 03 03 50 00000005 10 2 2
00000000A800 5F 5F 5F FFFFF800 40 2 2
00000000B123 5F 5F 5F 00000123 41 2 2
000000006235 02 03 51 00000000 07 2 2
000000009410 04 53 5F 00000010 07 2 2
00000000D7FF 07 54 5F 000000FF 08 2 2
000000004118 01 01 50 00000008 16 2 2
000000004229 02 02 50 FFFFFFF0 16 2 2
000000000009 5F 5F 5F 00000000 00 2 2
00000000000B 5F 5F 5F 00000000 46 2 2
000000003451 5F 5F 5F 00000000 FF 2 2
000045138E67 05 06 07 00000000 11 4 2
000089348E80 5F 5F 5F FFFF8034 42 4 2
000061268E34 01 02 03 00000004 0B 4 2
8E0034568A12 00 5F 5F 00123456 02 4 4
000900018AF0 00 5F 5F FFF00001 02 4 2
8C00FFFF8A7F 00 5F 5F 007FFFFF 02 4 4
00008A006153 01 05 5F 00000000 01 2 4
00000000632C 03 02 5F 00000000 20 2 2
00000000E5FE 05 05 50 FFFFFFFE 02 2 2
000000003120 5F 01 02 00000000 30 2 2
000000002312 03 01 5F 00000000 05 2 2
000000001234 02 03 5F 00000004 05 2 2
00000000F123 5F 5F 5F 00000000 FF 2 2
